//--- common/mem_pkg.sv
package mem_pkg;

    // word and address width are the same
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = WORD_W * LINE_WORDS;
    localparam int OFFSET_W   = 4;  // byte offset bits within a line

    // one cache line, seen whole on memory ports or word by word inside the caches
    typedef union packed {
        logic [LINE_W-1:0]                 raw;
        logic [LINE_WORDS-1:0][WORD_W-1:0] words;
    } cache_line_u;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] line_addr;  // byte address >> OFFSET_W, zero padded
    } mem_rd_req_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] line_addr;
        cache_line_u       line;
    } mem_wr_req_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] line_addr;  // echoed from the request
        cache_line_u       line;
    } mem_rsp_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [WORD_W-1:0] adr;
        logic [WORD_W-1:0] dat;
    } wb_req_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic              ack;
        logic [WORD_W-1:0] dat;
    } wb_rsp_t;

endpackage

//--- memory/line_memory.sv
module line_memory #(
    parameter int MEM_DELAY_CYCLES = 4,
    parameter int MEM_LINES        = 256
) (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  mem_pkg::mem_rd_req_t i_irq,   // instruction fetch read port
    output mem_pkg::mem_rsp_t    o_irsp,
    input  mem_pkg::mem_rd_req_t i_drq,   // data read port
    output mem_pkg::mem_rsp_t    o_drsp,
    input  mem_pkg::mem_wr_req_t i_wrq    // data line write port
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(MEM_LINES);
    localparam int LAST  = MEM_DELAY_CYCLES - 1;

    cache_line_u mem_q [MEM_LINES];

    // stage 0 takes the new request, stage LAST is the one served
    logic [MEM_DELAY_CYCLES-1:0] irq_vld_q;
    logic [MEM_DELAY_CYCLES-1:0] drq_vld_q;
    logic [MEM_DELAY_CYCLES-1:0] wrq_vld_q;
    logic [WORD_W-1:0]           irq_addr_q [MEM_DELAY_CYCLES];
    logic [WORD_W-1:0]           drq_addr_q [MEM_DELAY_CYCLES];
    logic [WORD_W-1:0]           wrq_addr_q [MEM_DELAY_CYCLES];
    cache_line_u                 wrq_line_q [MEM_DELAY_CYCLES];

    initial begin
        for (int i = 0; i < MEM_LINES; i++) begin
            mem_q[i] = '0;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            irq_vld_q <= '0;
            drq_vld_q <= '0;
            wrq_vld_q <= '0;
        end else begin
            irq_vld_q[0] <= i_irq.valid;
            drq_vld_q[0] <= i_drq.valid;
            wrq_vld_q[0] <= i_wrq.valid;
            for (int k = 1; k < MEM_DELAY_CYCLES; k++) begin
                irq_vld_q[k] <= irq_vld_q[k-1];
                drq_vld_q[k] <= drq_vld_q[k-1];
                wrq_vld_q[k] <= wrq_vld_q[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        irq_addr_q[0] <= i_irq.line_addr;
        drq_addr_q[0] <= i_drq.line_addr;
        wrq_addr_q[0] <= i_wrq.line_addr;
        wrq_line_q[0] <= i_wrq.line;
        for (int k = 1; k < MEM_DELAY_CYCLES; k++) begin
            irq_addr_q[k] <= irq_addr_q[k-1];
            drq_addr_q[k] <= drq_addr_q[k-1];
            wrq_addr_q[k] <= wrq_addr_q[k-1];
            wrq_line_q[k] <= wrq_line_q[k-1];
        end
    end

    // write lands when it leaves the pipeline, address wraps on MEM_LINES
    always @(posedge clk) begin
        if (wrq_vld_q[LAST]) begin
            mem_q[wrq_addr_q[LAST][IDX_W-1:0]] <= wrq_line_q[LAST];
        end
    end

    always_comb begin
        o_irsp.valid     = irq_vld_q[LAST];
        o_irsp.line_addr = irq_addr_q[LAST];
        o_irsp.line      = mem_q[irq_addr_q[LAST][IDX_W-1:0]];
        o_drsp.valid     = drq_vld_q[LAST];
        o_drsp.line_addr = drq_addr_q[LAST];
        o_drsp.line      = mem_q[drq_addr_q[LAST][IDX_W-1:0]];
    end

    a_delay_min: assert property (@(posedge clk) MEM_DELAY_CYCLES >= 1);

endmodule

//--- icache/icache.sv
module icache #(
    parameter int CACHE_LINES = 8
) (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  mem_pkg::wb_req_t     i_wb,
    output mem_pkg::wb_rsp_t     o_wb,
    output mem_pkg::mem_rd_req_t o_mrq,
    input  mem_pkg::mem_rsp_t    i_mrsp
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = WORD_W - OFFSET_W - IDX_W;
    localparam int SEL_W = $clog2(LINE_WORDS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_MISS_WAIT,
        S_RESPOND
    } state_e;

    state_e                 state_q;
    logic [CACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]       tag_q  [CACHE_LINES];
    cache_line_u            line_q [CACHE_LINES];
    logic                   ack_q;
    logic [WORD_W-1:0]      dat_q;
    logic                   mrq_vld_q;
    logic [WORD_W-1:0]      req_line_q;  // line address of the current request

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic [SEL_W-1:0] sel;
    logic             req;
    logic             hit;
    logic             fill;

    assign idx  = i_wb.adr[OFFSET_W +: IDX_W];
    assign tag  = i_wb.adr[WORD_W-1 -: TAG_W];
    assign sel  = i_wb.adr[OFFSET_W-SEL_W +: SEL_W];
    assign req  = i_wb.cyc && i_wb.stb && !ack_q;  // stb is still up while ack is seen
    assign hit  = valid_q[idx] && (tag_q[idx] == tag);
    assign fill = (state_q == S_MISS_WAIT) && i_mrsp.valid && (i_mrsp.line_addr == req_line_q);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q   <= S_IDLE;
            valid_q   <= '0;
            ack_q     <= 1'b0;
            mrq_vld_q <= 1'b0;
        end else begin
            ack_q     <= 1'b0;
            mrq_vld_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (req && (i_wb.we || hit)) begin
                        ack_q <= 1'b1;  // hit, or a write that is dropped
                    end else if (req) begin
                        mrq_vld_q <= 1'b1;
                        state_q   <= S_MISS_WAIT;
                    end
                end
                S_MISS_WAIT: begin
                    if (fill) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= S_RESPOND;
                    end
                end
                S_RESPOND: begin
                    ack_q   <= 1'b1;
                    state_q <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req) begin
            req_line_q <= {{OFFSET_W{1'b0}}, i_wb.adr[WORD_W-1:OFFSET_W]};
            dat_q      <= i_wb.we ? '0 : line_q[idx].words[sel];
        end
        if (fill) begin
            tag_q[idx]  <= tag;
            line_q[idx] <= i_mrsp.line;
        end
        if (state_q == S_RESPOND) begin
            dat_q <= line_q[idx].words[sel];
        end
    end

    assign o_wb.ack        = ack_q;
    assign o_wb.dat        = dat_q;
    assign o_mrq.valid     = mrq_vld_q;
    assign o_mrq.line_addr = req_line_q;

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_wb.ack |-> (i_wb.cyc && i_wb.stb));

    // memory only answers our own single outstanding miss
    a_rsp_in_miss: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_mrsp.valid |-> (state_q == S_MISS_WAIT));

endmodule

//--- dcache/dcache.sv
module dcache #(
    parameter int CACHE_LINES = 8
) (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  mem_pkg::wb_req_t     i_wb,
    output mem_pkg::wb_rsp_t     o_wb,
    output mem_pkg::mem_rd_req_t o_mrq,
    input  mem_pkg::mem_rsp_t    i_mrsp,
    output mem_pkg::mem_wr_req_t o_mwr
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = WORD_W - OFFSET_W - IDX_W;
    localparam int SEL_W = $clog2(LINE_WORDS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_MISS_WAIT,
        S_RESPOND
    } state_e;

    state_e                 state_q;
    logic [CACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]       tag_q  [CACHE_LINES];
    cache_line_u            line_q [CACHE_LINES];
    logic                   ack_q;
    logic [WORD_W-1:0]      dat_q;
    logic                   mrq_vld_q;
    logic                   mwr_vld_q;
    logic [WORD_W-1:0]      req_line_q;
    cache_line_u            mwr_line_q;

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic [SEL_W-1:0] sel;
    logic             req;
    logic             hit;
    logic             fill;
    cache_line_u      merged;  // cached line with the store word dropped in

    assign idx  = i_wb.adr[OFFSET_W +: IDX_W];
    assign tag  = i_wb.adr[WORD_W-1 -: TAG_W];
    assign sel  = i_wb.adr[OFFSET_W-SEL_W +: SEL_W];
    assign req  = i_wb.cyc && i_wb.stb && !ack_q;
    assign hit  = valid_q[idx] && (tag_q[idx] == tag);
    assign fill = (state_q == S_MISS_WAIT) && i_mrsp.valid && (i_mrsp.line_addr == req_line_q);

    always_comb begin
        merged            = line_q[idx];
        merged.words[sel] = i_wb.dat;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q   <= S_IDLE;
            valid_q   <= '0;
            ack_q     <= 1'b0;
            mrq_vld_q <= 1'b0;
            mwr_vld_q <= 1'b0;
        end else begin
            ack_q     <= 1'b0;
            mrq_vld_q <= 1'b0;
            mwr_vld_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (req && hit) begin
                        ack_q     <= 1'b1;
                        mwr_vld_q <= i_wb.we;  // write-through on every store
                    end else if (req) begin
                        mrq_vld_q <= 1'b1;  // allocate on reads and writes alike
                        state_q   <= S_MISS_WAIT;
                    end
                end
                S_MISS_WAIT: begin
                    if (fill) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= S_RESPOND;
                    end
                end
                S_RESPOND: begin
                    ack_q     <= 1'b1;
                    mwr_vld_q <= i_wb.we;
                    state_q   <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req) begin
            req_line_q <= {{OFFSET_W{1'b0}}, i_wb.adr[WORD_W-1:OFFSET_W]};
            dat_q      <= line_q[idx].words[sel];
        end
        if (fill) begin
            tag_q[idx]  <= tag;
            line_q[idx] <= i_mrsp.line;
        end
        if (state_q == S_RESPOND) begin
            dat_q <= line_q[idx].words[sel];
        end
        // store merge, on a hit straight away or after the fill
        if (i_wb.we && ((state_q == S_IDLE && req && hit) || state_q == S_RESPOND)) begin
            line_q[idx] <= merged;
            mwr_line_q  <= merged;
        end
    end

    assign o_wb.ack        = ack_q;
    assign o_wb.dat        = dat_q;
    assign o_mrq.valid     = mrq_vld_q;
    assign o_mrq.line_addr = req_line_q;
    assign o_mwr.valid     = mwr_vld_q;
    assign o_mwr.line_addr = req_line_q;
    assign o_mwr.line      = mwr_line_q;

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_wb.ack |-> (i_wb.cyc && i_wb.stb));

    a_wr_with_ack: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_mwr.valid |-> (o_wb.ack && i_wb.we));

endmodule

//--- logic/mem_subsystem.sv
module mem_subsystem #(
    parameter int MEM_DELAY_CYCLES = 4,
    parameter int MEM_LINES        = 256,  // power of two
    parameter int CACHE_LINES      = 8     // power of two
) (
    input  logic             clk,
    input  logic             i_arst_n,
    input  mem_pkg::wb_req_t i_ibus,  // instruction port
    output mem_pkg::wb_rsp_t o_ibus,
    input  mem_pkg::wb_req_t i_dbus,  // data port
    output mem_pkg::wb_rsp_t o_dbus
);
    import mem_pkg::*;

    mem_rd_req_t irq;
    mem_rsp_t    irsp;
    mem_rd_req_t drq;
    mem_rsp_t    drsp;
    mem_wr_req_t wrq;  // data side line writes

    icache #(
        .CACHE_LINES(CACHE_LINES)
    ) u_icache (
        .clk     (clk),
        .i_arst_n(i_arst_n),
        .i_wb    (i_ibus),
        .o_wb    (o_ibus),
        .o_mrq   (irq),
        .i_mrsp  (irsp)
    );

    dcache #(
        .CACHE_LINES(CACHE_LINES)
    ) u_dcache (
        .clk     (clk),
        .i_arst_n(i_arst_n),
        .i_wb    (i_dbus),
        .o_wb    (o_dbus),
        .o_mrq   (drq),
        .i_mrsp  (drsp),
        .o_mwr   (wrq)
    );

    line_memory #(
        .MEM_DELAY_CYCLES(MEM_DELAY_CYCLES),
        .MEM_LINES       (MEM_LINES)
    ) u_line_memory (
        .clk     (clk),
        .i_arst_n(i_arst_n),
        .i_irq   (irq),
        .o_irsp  (irsp),
        .i_drq   (drq),
        .o_drsp  (drsp),
        .i_wrq   (wrq)
    );

endmodule

//--- dv/mem_checker.sv
module mem_checker (
    input  logic             clk,
    input  logic             i_arst_n,
    input  mem_pkg::wb_rsp_t i_irsp,  // instruction port response
    input  mem_pkg::wb_rsp_t i_drsp,  // data port response
    input  logic             i_ipush,
    input  logic             i_iexp_chk,
    input  logic [31:0]      i_iexp_adr,
    input  logic [31:0]      i_iexp_dat,
    input  logic             i_dpush,
    input  logic             i_dexp_chk,
    input  logic [31:0]      i_dexp_adr,
    input  logic [31:0]      i_dexp_dat,
    output int               o_errors
);
    import mem_pkg::*;

    localparam int ENT_W = 2 * WORD_W + 1;

    // entry holds check flag, address and expected data, oldest request first
    logic [ENT_W-1:0] iq [$];
    logic [ENT_W-1:0] dq [$];
    logic [ENT_W-1:0] ient;
    logic [ENT_W-1:0] dent;
    int               errors = 0;

    task automatic check_ack(input string port, input logic [ENT_W-1:0] ent,
                             input logic [WORD_W-1:0] got);
        if (ent[ENT_W-1] && got !== ent[WORD_W-1:0]) begin
            $display("Fail at time %0t: port %s read of %h got %h expected %h",
                     $time, port, ent[2*WORD_W-1:WORD_W], got, ent[WORD_W-1:0]);
            errors++;
        end
    endtask

    // requests are driven on the falling edge, so they are steady here
    always @(posedge clk) begin
        if (i_ipush) begin
            iq.push_back({i_iexp_chk, i_iexp_adr, i_iexp_dat});
        end
        if (i_dpush) begin
            dq.push_back({i_dexp_chk, i_dexp_adr, i_dexp_dat});
        end
    end

    // ack and read data come from flops, sampled half a cycle later
    always @(negedge clk) begin
        if (i_arst_n && i_irsp.ack) begin
            if (iq.size() == 0) begin
                $display("port I acked while no request was outstanding");
                errors++;
            end else begin
                ient = iq.pop_front();
                check_ack("I", ient, i_irsp.dat);
            end
        end
        if (i_arst_n && i_drsp.ack) begin
            if (dq.size() == 0) begin
                $display("port D acked while no request was outstanding");
                errors++;
            end else begin
                dent = dq.pop_front();
                check_ack("D", dent, i_drsp.dat);
            end
        end
    end

    assign o_errors = errors;

endmodule

//--- dv/tb_mem_subsystem.sv
module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int MEM_DELAY_CYCLES = 4;
    localparam int MEM_LINES        = 256;
    localparam int CACHE_LINES      = 8;
    localparam int MAX_ENTRIES      = 64;
    localparam int REQ_TIMEOUT      = 100;   // cycles for one request to ack
    localparam int SYNC_TIMEOUT     = 2000;  // cycles one port may wait for the other

    logic              clk;
    logic              arst_n;
    wb_req_t           bus_req [2];  // 0 is the instruction port, 1 the data port
    wb_rsp_t           bus_rsp [2];
    logic              push    [2];  // one cycle pulse, hands an expectation to the checker
    logic              exp_chk [2];
    logic [WORD_W-1:0] exp_adr [2];
    logic [WORD_W-1:0] exp_dat [2];
    int                arrived [2];  // barriers reached per port
    int                chk_errors;
    int                timeouts;
    int                bad_trace;

    logic [7:0]        tr_port [MAX_ENTRIES];
    int                tr_we   [MAX_ENTRIES];
    logic [WORD_W-1:0] tr_adr  [MAX_ENTRIES];
    logic [WORD_W-1:0] tr_wdat [MAX_ENTRIES];
    int                tr_chk  [MAX_ENTRIES];
    logic [WORD_W-1:0] tr_exp  [MAX_ENTRIES];
    int                n_entries;

    mem_subsystem #(
        .MEM_DELAY_CYCLES(MEM_DELAY_CYCLES),
        .MEM_LINES       (MEM_LINES),
        .CACHE_LINES     (CACHE_LINES)
    ) i_dut (
        .clk     (clk),
        .i_arst_n(arst_n),
        .i_ibus  (bus_req[0]),
        .o_ibus  (bus_rsp[0]),
        .i_dbus  (bus_req[1]),
        .o_dbus  (bus_rsp[1])
    );

    mem_checker u_checker (
        .clk       (clk),
        .i_arst_n  (arst_n),
        .i_irsp    (bus_rsp[0]),
        .i_drsp    (bus_rsp[1]),
        .i_ipush   (push[0]),
        .i_iexp_chk(exp_chk[0]),
        .i_iexp_adr(exp_adr[0]),
        .i_iexp_dat(exp_dat[0]),
        .i_dpush   (push[1]),
        .i_dexp_chk(exp_chk[1]),
        .i_dexp_adr(exp_adr[1]),
        .i_dexp_dat(exp_dat[1]),
        .o_errors  (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic load_trace();
        int         fd;
        int         c;
        int         got;
        logic [7:0] ch;
        n_entries = 0;
        fd = $fopen("dv/mem_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file dv/mem_trace.txt");
            bad_trace++;
            return;
        end
        while (n_entries < MAX_ENTRIES) begin
            c = $fgetc(fd);
            if (c < 0) break;
            ch = c[7:0];
            if (ch == "#") begin
                while (c >= 0 && c[7:0] != "\n") c = $fgetc(fd);  // comment runs to end of line
            end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
                got = $fscanf(fd, "%d %h %h %d %h", tr_we[n_entries], tr_adr[n_entries],
                              tr_wdat[n_entries], tr_chk[n_entries], tr_exp[n_entries]);
                if (got != 5) begin
                    $display("trace entry %0d is malformed", n_entries);
                    bad_trace++;
                    break;
                end
                tr_port[n_entries] = ch;
                n_entries++;
            end
        end
        $fclose(fd);
        if (n_entries == 0) begin
            $display("the trace holds no entries");
            bad_trace++;
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic do_request(input int p, input int n);
        wb_req_t rq;
        int      waited;
        rq.cyc = 1'b1;
        rq.stb = 1'b1;
        rq.we  = (tr_we[n] != 0);
        rq.adr = tr_adr[n];
        rq.dat = tr_wdat[n];
        bus_req[p] = rq;
        exp_chk[p] = (tr_chk[n] != 0);
        exp_adr[p] = tr_adr[n];
        exp_dat[p] = tr_exp[n];
        push[p]    = 1'b1;
        waited     = 0;
        do begin
            @(negedge clk);
            push[p] = 1'b0;
            waited++;
        end while (!bus_rsp[p].ack && waited < REQ_TIMEOUT);
        if (!bus_rsp[p].ack) begin
            $display("timeout: port %s address %h was not acked within %0d cycles",
                     tr_port[n], tr_adr[n], REQ_TIMEOUT);
            timeouts++;
            bus_req[p] = '0;
        end
        @(negedge clk);  // ack is still high at the next edge, keep the request up through it
        bus_req[p] = '0;  // stb drops unless the next request follows right away
    endtask

    // both drivers line up here so that later entries see earlier writes
    task automatic meet_other_port(input int p);
        int waited;
        waited = 0;
        arrived[p]++;
        do begin
            @(posedge clk);
            waited++;
        end while (arrived[1-p] < arrived[p] && waited < SYNC_TIMEOUT);
        if (arrived[1-p] < arrived[p]) begin
            $display("timeout: port %0d waited too long for the other port at a barrier", p);
            timeouts++;
        end
        @(negedge clk);  // both ports leave on the same falling edge
    endtask

    task automatic run_port(input int p);
        logic [7:0] me;
        me = (p == 0) ? "I" : "D";
        for (int n = 0; n < n_entries; n++) begin
            if (tr_port[n] == "B") begin
                meet_other_port(p);
            end else if (tr_port[n] == me) begin
                do_request(p, n);
            end
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        timeouts  = 0;
        bad_trace = 0;
        for (int p = 0; p < 2; p++) begin
            bus_req[p] = '0;
            push[p]    = 1'b0;
            exp_chk[p] = 1'b0;
            exp_adr[p] = '0;
            exp_dat[p] = '0;
            arrived[p] = 0;
        end
        load_trace();
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        fork
            run_port(0);
            run_port(1);
        join
        repeat (4) @(negedge clk);
        $display("errors %0d, timeouts %0d, trace problems %0d", chk_errors, timeouts, bad_trace);
        if (chk_errors == 0 && timeouts == 0 && bad_trace == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- dv/mem_trace.txt
# port (I, D, or B for a barrier where both drivers line up), write flag, address (hex),
# write data (hex), read-expected flag, expected read data (hex)
I 0 00000000 00000000 1 00000000
D 0 00000300 00000000 1 00000000
I 0 0000000c 00000000 1 00000000
D 0 0000040c 00000000 1 00000000
I 0 00000104 00000000 1 00000000
I 0 00000208 00000000 1 00000000
I 0 00000000 00000000 1 00000000
I 0 000007f0 00000000 1 00000000
D 1 00000500 11111111 0 00000000
D 1 00000504 22222222 0 00000000
D 1 00000508 33333333 0 00000000
D 1 0000050c 44444444 0 00000000
D 1 00000504 a5a5a5a5 0 00000000
D 0 00000500 00000000 1 11111111
D 0 00000504 00000000 1 a5a5a5a5
D 0 00000508 00000000 1 33333333
D 0 0000050c 00000000 1 44444444
D 1 00000624 deadbeef 0 00000000
D 1 000006a8 cafef00d 0 00000000
D 0 00000624 00000000 1 deadbeef
D 0 000006a8 00000000 1 cafef00d
D 0 00000620 00000000 1 00000000
D 1 00000a2c 0badc0de 0 00000000
D 0 00000624 00000000 1 deadbeef
D 0 00000a2c 00000000 1 0badc0de
B 0 00000000 00000000 0 00000000
I 0 00000500 00000000 1 11111111
D 1 00000804 12345678 0 00000000
I 0 00000504 00000000 1 a5a5a5a5
D 0 00000804 00000000 1 12345678
I 0 0000050c 00000000 1 44444444
D 0 00000800 00000000 1 00000000
I 0 000006a8 00000000 1 cafef00d
D 1 00000924 87654321 0 00000000
I 0 00000a2c 00000000 1 0badc0de
D 0 00000a2c 00000000 1 0badc0de
I 0 00000624 00000000 1 deadbeef
D 0 00000924 00000000 1 87654321
D 0 00000504 00000000 1 a5a5a5a5

//--- src.f
common/mem_pkg.sv
memory/line_memory.sv
icache/icache.sv
dcache/dcache.sv
logic/mem_subsystem.sv
dv/mem_checker.sv
dv/tb_mem_subsystem.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 -f src.f --top-module tb_mem_subsystem -o tb_mem_subsystem &&
./obj_dir/tb_mem_subsystem | tee /dev/stderr | grep -q "All tests passed!" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
